// ==== project.f ====
design/riscv_pkg.sv
design/alu.sv
design/fetch_unit.sv
design/decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/mem_stage.sv
design/core_top.sv
verification/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/core_tb.sv ====
// --------------------
// rv32i core testbench
// --------------------

module core_tb import riscv_pkg::*; ();

    localparam int          max_wait  = 20;
    localparam logic [31:0] nop       = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] data_base = 32'h0000_1000;

    logic            clk        = 1'b0;
    logic            reset      = 1'b1;
    logic            imem_req;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_rdata = nop;
    dmem_req_t       dmem_req;
    logic [xlen-1:0] dmem_rdata = '0;
    retire_t         retire;

    logic [31:0] imem [logic [31:0]];
    logic [7:0]  data_mem [256];
    logic [7:0]  ref_mem [256];    // expected data memory contents
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc;
    logic        have_prev = 1'b0;
    dmem_req_t   last_req;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #2 clk = ~clk;

    core_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .retire     (retire)
    );

    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return (a * 8'd29) ^ 8'h5a;
    endfunction

    // both memories answer one cycle after the request
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                data_mem[i] <= fill_byte(8'(i));
            end
        end else begin
            if (imem_req) begin
                imem_rdata <= imem.exists(imem_addr) ? imem[imem_addr] : nop;
            end
            if (dmem_req.valid && dmem_req.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (dmem_req.be[i]) begin
                        data_mem[{dmem_req.addr[7:2], 2'(i)}] <= dmem_req.wdata[8*i +: 8];
                    end
                end
            end else if (dmem_req.valid) begin
                dmem_rdata <= {data_mem[{dmem_req.addr[7:2], 2'd3}],
                               data_mem[{dmem_req.addr[7:2], 2'd2}],
                               data_mem[{dmem_req.addr[7:2], 2'd1}],
                               data_mem[{dmem_req.addr[7:2], 2'd0}]};
            end
        end
    end

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // reference results straight from the ISA rules
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        logic lt_s;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return lt_s;
            3'd5:    return !lt_s;
            3'd6:    return a < b;
            default: return !(a < b);
        endcase
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [7:0] i;
        i = addr[7:0];
        case (f3)
            3'd0:    return {{24{ref_mem[i][7]}}, ref_mem[i]};
            3'd1:    return {{16{ref_mem[i + 8'd1][7]}}, ref_mem[i + 8'd1], ref_mem[i]};
            3'd4:    return {24'b0, ref_mem[i]};
            3'd5:    return {16'b0, ref_mem[i + 8'd1], ref_mem[i]};
            default: return {ref_mem[i + 8'd3], ref_mem[i + 8'd2], ref_mem[i + 8'd1], ref_mem[i]};
        endcase
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, want);
            test_errors++;
        end
    endtask

    task automatic check_retire(input string what, input retire_t got, input retire_t want);
        if (got.valid !== want.valid || got.pc !== want.pc || got.rd !== want.rd ||
                got.we !== want.we || (want.we && got.data !== want.data)) begin
            $display("[FAIL] %0t: %s pc %h/%h rd %0d/%0d we %b/%b data %h/%h (got/expected)",
                     $time, what, got.pc, want.pc, got.rd, want.rd, got.we, want.we,
                     got.data, want.data);
            test_errors++;
        end
    endtask

    task automatic check_dmem_req(input string what, input dmem_req_t got, input dmem_req_t want);
        if (got.valid !== want.valid || got.we !== want.we || got.addr !== want.addr ||
                (want.we && (got.be !== want.be || got.wdata !== want.wdata))) begin
            $display("[FAIL] %0t: %s addr %h/%h be %b/%b wdata %h/%h (got/expected)",
                     $time, what, got.addr, want.addr, got.be, want.be, got.wdata, want.wdata);
            test_errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout waiting for %s at time %0t", what, $time);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors += test_errors;
        $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    // fetch one instruction at the core's pc and follow it to retirement
    task automatic run_inst(input logic [31:0] inst, input logic is_mem, input logic exp_we,
                            input logic [31:0] exp_data, input logic [31:0] next_pc);
        int      gap;
        int      lat;
        retire_t want;
        gap = 0;
        while (!imem_req) begin
            @(negedge clk);
            gap++;
            if (gap > max_wait) abort_on_timeout("imem_req");
        end
        if (have_prev) check_word("fetch after retire", 32'(gap), 32'd1);
        check_word("fetch addr", imem_addr, exp_pc);
        imem[imem_addr] = inst;
        last_req = '0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (dmem_req.valid) last_req = dmem_req;
            if (lat > max_wait) abort_on_timeout("retire");
        end while (!retire.valid);
        check_word("retire latency", 32'(lat), is_mem ? 32'd2 : 32'd1);
        if (!is_mem) check_dmem_req("no data request", last_req, '0);
        want = '{valid: 1'b1, pc: exp_pc, rd: inst[11:7], we: exp_we, data: exp_data};
        check_retire("retire", retire, want);
        if (exp_we) model_regs[inst[11:7]] = exp_data;
        exp_pc = next_pc;
        have_prev = 1'b1;
    endtask

    task automatic alu_inst(input logic [31:0] inst, input logic [31:0] result);
        run_inst(inst, 1'b0, inst[11:7] != 5'd0, result, exp_pc + 32'd4);
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = 20'((value + 32'h800) >> 12);  // addi sign extends its low 12 bits
        alu_inst(u_type(hi, rd, opc_lui), {hi, 12'b0});
        alu_inst(i_type(value[11:0], rd, 3'd0, rd, opc_op_imm),
                 model_alu(3'd0, 1'b0, model_regs[rd], {{20{value[11]}}, value[11:0]}));
    endtask

    task automatic test_reset();
        int cycles;
        cycles = 0;
        @(negedge clk);  // reset still seen at the edge before
        while (!imem_req) begin
            @(negedge clk);
            cycles++;
            check_word("retire before first fetch", 32'(retire.valid), 32'd0);
            if (cycles > max_wait) abort_on_timeout("first imem_req");
        end
        check_word("cycles to first fetch", 32'(cycles), 32'd1);
        check_word("first fetch addr", imem_addr, reset_pc);
        report_test("reset and first fetch");
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        logic [19:0] up;
        set_reg(5'd1, $urandom() | 32'h8000_0000);  // negative so that sra and srl differ
        set_reg(5'd2, $urandom());
        for (int f3 = 0; f3 < 8; f3++) begin
            alu_inst(r_type(7'h00, 5'd2, 5'd1, 3'(f3), 5'd3),
                     model_alu(3'(f3), 1'b0, model_regs[1], model_regs[2]));
            imm = (f3 == 1 || f3 == 5) ? {7'h00, 5'($urandom())} : 12'($urandom());
            alu_inst(i_type(imm, 5'd1, 3'(f3), 5'd4, opc_op_imm),
                     model_alu(3'(f3), 1'b0, model_regs[1], {{20{imm[11]}}, imm}));
        end
        alu_inst(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd3),
                 model_alu(3'd0, 1'b1, model_regs[1], model_regs[2]));
        alu_inst(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd3),
                 model_alu(3'd5, 1'b1, model_regs[1], model_regs[2]));
        imm = {7'h20, 5'($urandom())};
        alu_inst(i_type(imm, 5'd1, 3'd5, 5'd4, opc_op_imm),
                 model_alu(3'd5, 1'b1, model_regs[1], {20'b0, imm}));
        up = 20'($urandom());
        alu_inst(u_type(up, 5'd5, opc_lui), {up, 12'b0});
        alu_inst(u_type(up, 5'd6, opc_auipc), exp_pc + {up, 12'b0});
        // x0 write retires with we low and a later read sees zero
        alu_inst(i_type(12'd5, 5'd1, 3'd0, 5'd0, opc_op_imm), 32'd0);
        alu_inst(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd7), 32'd0);
        report_test("arithmetic and upper immediates");
    endtask

    task automatic test_branch();
        logic [12:0] off;
        logic [20:0] joff;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        taken;
        set_reg(5'd1, $urandom() | 32'h8000_0000);
        set_reg(5'd2, $urandom() & 32'h7fff_ffff);
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) continue;
            // operand pairs (x1,x2), (x2,x1), (x1,x1) give taken and not taken
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : 5'd1;
                off = 13'(($urandom_range(31) + 1) * 4);
                if ($urandom_range(1) == 1) off = -off;
                taken = branch_taken(3'(f3), model_regs[rs1], model_regs[rs2]);
                run_inst(b_type(off, rs2, rs1, 3'(f3)), 1'b0, 1'b0, 32'd0,
                         taken ? exp_pc + {{19{off[12]}}, off} : exp_pc + 32'd4);
            end
        end
        joff = 21'(($urandom_range(255) + 1) * 4);
        run_inst(j_type(joff, 5'd8), 1'b0, 1'b1, exp_pc + 32'd4, exp_pc + {{11{joff[20]}}, joff});
        set_reg(5'd9, 32'h8000_0400);
        run_inst(i_type(12'h021, 5'd9, 3'd0, 5'd10, opc_jalr), 1'b0, 1'b1, exp_pc + 32'd4,
                 (model_regs[9] + 32'h21) & ~32'd1);
        report_test("branches and jumps");
    endtask

    task automatic test_store();
        logic [31:0] v;
        logic [31:0] addr;
        logic [2:0]  f3;
        int          offs;
        int          nbytes;
        dmem_req_t   want;
        set_reg(5'd11, data_base);
        // sb at 0..3, sh at 4 and 6, sw at 8
        for (int k = 0; k < 7; k++) begin
            v = $urandom();
            set_reg(5'd12, v);
            f3 = (k < 4) ? 3'd0 : (k < 6) ? 3'd1 : 3'd2;
            nbytes = (k < 4) ? 1 : (k < 6) ? 2 : 4;
            offs = (k < 4) ? k : (k < 6) ? 4 + 2 * (k - 4) : 8;
            addr = data_base + 32'(offs);
            want = '{valid: 1'b1, we: 1'b1, addr: addr, wdata: '0, be: '0};
            // enabled lanes and store data repeated from the low bytes of rs2
            for (int i = 0; i < 4; i++) begin
                want.be[i]           = (i >= offs % 4) && (i < offs % 4 + nbytes);
                want.wdata[8*i +: 8] = v[8*(i % nbytes) +: 8];
            end
            run_inst(s_type(12'(offs), 5'd12, 5'd11, f3), 1'b1, 1'b0, 32'd0, exp_pc + 32'd4);
            check_dmem_req("store request", last_req, want);
            for (int i = 0; i < 4; i++) begin
                if (want.be[i]) ref_mem[{addr[7:2], 2'(i)}] = want.wdata[8*i +: 8];
            end
        end
        report_test("stores");
    endtask

    task automatic test_load();
        logic [31:0] addr;
        logic [2:0]  f3;
        int          offs;
        dmem_req_t   want;
        set_reg(5'd11, data_base);
        for (int k = 0; k < 20; k++) begin
            if (k < 8) begin
                f3   = (k >= 4) ? 3'd4 : 3'd0;      // lb then lbu
                offs = k % 4;
            end else if (k < 16) begin
                f3   = (k >= 12) ? 3'd5 : 3'd1;     // lh then lhu
                offs = 2 * (k % 4);
            end else begin
                f3   = 3'd2;
                offs = 4 * (k - 16);                // last word still holds the fill
            end
            addr = data_base + 32'(offs);
            want = '{valid: 1'b1, we: 1'b0, addr: addr, wdata: '0, be: '0};
            run_inst(i_type(12'(offs), 5'd11, f3, 5'd13, opc_load), 1'b1, 1'b1,
                     model_load(f3, addr), exp_pc + 32'd4);
            check_dmem_req("load request", last_req, want);
        end
        report_test("loads");
    endtask

    // alternating memory and alu instructions
    task automatic test_phase();
        run_inst(i_type(12'd0, 5'd11, 3'd2, 5'd14, opc_load), 1'b1, 1'b1,
                 model_load(3'd2, data_base), exp_pc + 32'd4);
        alu_inst(i_type(12'h155, 5'd0, 3'd0, 5'd15, opc_op_imm), 32'h0000_0155);
        run_inst(i_type(12'd6, 5'd11, 3'd5, 5'd16, opc_load), 1'b1, 1'b1,
                 model_load(3'd5, data_base + 32'd6), exp_pc + 32'd4);
        alu_inst(r_type(7'h00, 5'd16, 5'd14, 3'd0, 5'd17),
                 model_alu(3'd0, 1'b0, model_regs[14], model_regs[16]));
        report_test("phase timing");
    endtask

    initial begin
        void'($urandom(32'hb523_2f88));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_byte(8'(i));
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp_pc = reset_pc;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_alu();
        test_branch();
        test_store();
        test_load();
        test_phase();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/core_top.sv ====
// --------------------
// rv32i core top
// --------------------

module core_top import riscv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic            imem_req,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_rdata,
    output dmem_req_t       dmem_req,
    input  logic [xlen-1:0] dmem_rdata,
    output retire_t         retire
);

    logic [xlen-1:0] pc;
    logic            mem_issue;
    logic            retire_en;
    ctrl_t           ctrl;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] exec_result;
    logic            jump_en;
    logic [xlen-1:0] jump_target;

    assign imem_addr = pc;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .is_mem      (ctrl.is_load | ctrl.is_store),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .phase       (),
        .imem_req    (imem_req),
        .mem_issue   (mem_issue),
        .retire_en   (retire_en)
    );

    decoder u_dec (
        .inst (imem_rdata),
        .ctrl (ctrl)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .wr       (retire),   // writeback rides on the retire record
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit u_exec (
        .ctrl        (ctrl),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .exec_result (exec_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    mem_stage u_mem (
        .ctrl        (ctrl),
        .pc          (pc),
        .mem_issue   (mem_issue),
        .retire_en   (retire_en),
        .exec_result (exec_result),
        .rs2_data    (rs2_data),
        .dmem_rdata  (dmem_rdata),
        .dmem_req    (dmem_req),
        .retire      (retire)
    );

endmodule

// ==== design/mem_stage.sv ====
// --------------------
// data access, retire
// --------------------

module mem_stage import riscv_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] pc,
    input  logic            mem_issue,
    input  logic            retire_en,
    input  logic [xlen-1:0] exec_result,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] dmem_rdata,
    output dmem_req_t       dmem_req,
    output retire_t         retire
);

    logic [1:0]      offset;
    logic [xlen-1:0] lane;
    logic [xlen-1:0] load_data;

    assign offset = exec_result[1:0];

    always_comb begin
        dmem_req.valid = mem_issue;
        dmem_req.we    = ctrl.is_store;
        dmem_req.addr  = exec_result;
        case (ctrl.funct3[1:0])
            2'b00: begin   // sb
                dmem_req.be    = 4'b0001 << offset;
                dmem_req.wdata = {4{rs2_data[7:0]}};
            end
            2'b01: begin   // sh
                dmem_req.be    = 4'b0011 << offset;
                dmem_req.wdata = {2{rs2_data[15:0]}};
            end
            default: begin
                dmem_req.be    = 4'b1111;
                dmem_req.wdata = rs2_data;
            end
        endcase
    end

    // addressed lane moved down to bit 0
    assign lane = dmem_rdata >> {offset, 3'b000};

    always_comb begin
        case (ctrl.funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};     // lb
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};   // lh
            3'b100:  load_data = {24'b0, lane[7:0]};
            3'b101:  load_data = {16'b0, lane[15:0]};
            default: load_data = dmem_rdata;                     // lw
        endcase
    end

    always_comb begin
        retire.valid = retire_en;
        retire.pc    = pc;
        retire.rd    = ctrl.rd;
        retire.we    = (ctrl.wb_sel != wb_none) && (ctrl.rd != '0);
        case (ctrl.wb_sel)
            wb_alu, wb_link: retire.data = exec_result; // link already pc+4
            wb_load:         retire.data = load_data;
            default:         retire.data = '0;
        endcase
    end

endmodule

// ==== design/execute_unit.sv ====
// --------------------
// execute and branch
// --------------------

module execute_unit import riscv_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic [xlen-1:0] exec_result,
    output logic            jump_en,
    output logic [xlen-1:0] jump_target
);

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;
    logic            is_jump;

    // operand select
    always_comb begin
        case (ctrl.opcode)
            opc_op_imm, opc_load, opc_store, opc_jalr: begin
                alu_a = rs1_data;
                alu_b = ctrl.imm;
            end
            opc_lui: begin
                alu_a = '0;
                alu_b = ctrl.imm;
            end
            opc_auipc, opc_branch, opc_jal: begin
                alu_a = pc;        // pc relative
                alu_b = ctrl.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (ctrl.alu_op),
        .y  (alu_y)
    );

    assign is_jump     = (ctrl.opcode == opc_jal) || (ctrl.opcode == opc_jalr);
    assign exec_result = is_jump ? pc + xlen'(4) : alu_y;  // link value for jumps

    always_comb begin
        jump_target = alu_y;
        jump_en     = 1'b0;
        case (ctrl.opcode)
            opc_jal:  jump_en = 1'b1;
            opc_jalr: begin
                jump_en     = 1'b1;
                jump_target = {alu_y[xlen-1:1], 1'b0};
            end
            opc_branch: begin
                case (ctrl.funct3)
                    3'b000:  jump_en = (rs1_data == rs2_data);
                    3'b001:  jump_en = (rs1_data != rs2_data);
                    3'b100:  jump_en = ($signed(rs1_data) < $signed(rs2_data));
                    3'b101:  jump_en = ($signed(rs1_data) >= $signed(rs2_data));
                    3'b110:  jump_en = (rs1_data < rs2_data);
                    3'b111:  jump_en = (rs1_data >= rs2_data);
                    default: jump_en = 1'b0;
                endcase
            end
            default: jump_en = 1'b0;
        endcase
    end

endmodule

// ==== design/reg_file.sv ====
// --------------------
// general registers
// --------------------

module reg_file import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  retire_t               wr,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.we) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/decoder.sv ====
// --------------------
// instruction decoder
// --------------------

module decoder import riscv_pkg::*; (
    input  logic [xlen-1:0] inst,
    output ctrl_t           ctrl
);

    opcode_t    opc;
    logic [6:0] funct7;
    logic [2:0] funct3;
    inst_fmt_t  fmt;

    assign opc    = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // format from the major opcode
    always_comb begin
        case (opc)
            opc_op:                          fmt = fmt_r;
            opc_op_imm, opc_load, opc_jalr:  fmt = fmt_i;
            opc_store:                       fmt = fmt_s;
            opc_branch:                      fmt = fmt_b;
            opc_lui, opc_auipc:              fmt = fmt_u;
            opc_jal:                         fmt = fmt_j;
            default:                         fmt = fmt_none;
        endcase
    end

    always_comb begin
        ctrl.opcode = opc;
        ctrl.funct3 = funct3;
        ctrl.rd     = inst[11:7];
        ctrl.rs1    = inst[19:15];
        ctrl.rs2    = inst[24:20];

        case (fmt)
            fmt_i:   ctrl.imm = {{20{inst[31]}}, inst[31:20]};
            fmt_s:   ctrl.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   ctrl.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   ctrl.imm = {inst[31:12], 12'b0};
            fmt_j:   ctrl.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: ctrl.imm = '0;  // r format has none
        endcase

        // address and link arithmetic all go through add
        ctrl.alu_op = alu_add;
        if (opc == opc_op || opc == opc_op_imm) begin
            case (funct3)
                3'b000:  ctrl.alu_op = (opc == opc_op && funct7[5]) ? alu_sub : alu_add;
                3'b001:  ctrl.alu_op = alu_sll;
                3'b010:  ctrl.alu_op = alu_slt;
                3'b011:  ctrl.alu_op = alu_sltu;
                3'b100:  ctrl.alu_op = alu_xor;
                3'b101:  ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
                3'b110:  ctrl.alu_op = alu_or;
                default: ctrl.alu_op = alu_and;
            endcase
        end

        case (opc)
            opc_op, opc_op_imm, opc_lui, opc_auipc: ctrl.wb_sel = wb_alu;
            opc_jal, opc_jalr:                      ctrl.wb_sel = wb_link;
            opc_load:                               ctrl.wb_sel = wb_load;
            default:                                ctrl.wb_sel = wb_none; // store, branch
        endcase

        ctrl.is_load  = (opc == opc_load);
        ctrl.is_store = (opc == opc_store);
    end

endmodule

// ==== design/fetch_unit.sv ====
// --------------------
// pc and phase FSM
// --------------------

module fetch_unit import riscv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            is_mem,
    input  logic            jump_en,
    input  logic [xlen-1:0] jump_target,
    output logic [xlen-1:0] pc,
    output phase_t          phase,
    output logic            imem_req,
    output logic            mem_issue,
    output logic            retire_en
);

    phase_t phase_nxt;

    // fetch only moves on once the strobe has actually gone out,
    // so the cycle right after reset just raises imem_req
    always_comb begin
        phase_nxt = phase;
        case (phase)
            ph_fetch: if (imem_req) phase_nxt = ph_exec;
            ph_exec:  phase_nxt = is_mem ? ph_mem : ph_fetch;
            ph_mem:   phase_nxt = ph_fetch;
            default:  phase_nxt = ph_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= ph_fetch;
            imem_req <= 1'b0;
        end else begin
            phase    <= phase_nxt;
            imem_req <= (phase_nxt == ph_fetch); // one cycle strobe per fetch
        end
    end

    assign mem_issue = (phase == ph_exec) && is_mem;
    assign retire_en = ((phase == ph_exec) && !is_mem) || (phase == ph_mem);

    // next pc taken at retirement
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (retire_en) begin
            pc <= jump_en ? jump_target : pc + xlen'(4);
        end
    end

endmodule

// ==== design/alu.sv ====
// --------------------
// integer ALU
// --------------------

module alu import riscv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_t         op,
    output logic [xlen-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts use 5 bits

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: y = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = $unsigned($signed(a) >>> shamt);
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

// ==== design/riscv_pkg.sv ====
// --------------------
// rv32i core package
// --------------------

package riscv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000; // first fetch

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none   // nothing decodable
    } inst_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_link,   // pc+4 of jal/jalr
        wb_load,
        wb_none
    } wb_sel_t;

    typedef enum logic [1:0] {
        ph_fetch,
        ph_exec,
        ph_mem
    } phase_t;

    // decoded control for the instruction held on imem_rdata
    typedef struct packed {
        opcode_t               opcode;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;    // sign extended
        alu_op_t               alu_op;
        wb_sel_t               wb_sel;
        logic                  is_load;
        logic                  is_store;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic [3:0]      be;     // one bit per byte lane
    } dmem_req_t;

    // one record per retired instruction, also the regfile write port
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic [xlen-1:0]       data;
    } retire_t;

endpackage
